// File: design/cp0_settings.svh
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

// Register numbers
`define CP0_INDEX           5'd0
`define CP0_RANDOM          5'd1
`define CP0_ENTRYLO0        5'd2
`define CP0_ENTRYLO1        5'd3
`define CP0_CONTEXT         5'd4
`define CP0_PAGEMASK        5'd5
`define CP0_WIRED           5'd6
`define CP0_BADVADDR        5'd8
`define CP0_COUNT           5'd9
`define CP0_ENTRYHI         5'd10
`define CP0_COMPARE         5'd11
`define CP0_STATUS          5'd12
`define CP0_CAUSE           5'd13
`define CP0_EPC             5'd14
`define CP0_PRID            5'd15   // EBase at select 1
`define CP0_CONFIG          5'd16   // Config1 at select 1
`define CP0_ERROREPC        5'd30

// Software writable bits
`define CP0_INDEX_MASK      32'h0000_001F
`define CP0_ENTRYLO0_MASK   32'h03FF_FFFF
`define CP0_ENTRYLO1_MASK   32'h03FF_FFFF
`define CP0_CONTEXT_MASK    32'hFF80_0000
`define CP0_PAGEMASK_MASK   32'h01FF_E000
`define CP0_WIRED_MASK      32'h0000_001F
`define CP0_COUNT_MASK      32'hFFFF_FFFF
`define CP0_ENTRYHI_MASK    32'hFFFF_E0FF
`define CP0_COMPARE_MASK    32'hFFFF_FFFF
`define CP0_STATUS_MASK     32'h1040_FF03   // CU0, BEV, IM, EXL, IE
`define CP0_CAUSE_MASK      32'h00C0_0300   // IV, WP, IP1..IP0
`define CP0_EPC_MASK        32'hFFFF_FFFF
`define CP0_EBASE_MASK      32'h3FFF_F000
`define CP0_CONFIG_MASK     32'h0000_0007   // K0 only
`define CP0_ERROREPC_MASK   32'hFFFF_FFFF

// Reset and fixed values
`define CP0_STATUS_RESET    32'h0040_0000
`define CP0_PRID_VALUE      32'h0000_8001
`define CP0_EBASE_RESET     32'h8000_0000
`define CP0_CONFIG_RESET    32'h8000_0083
`define CP0_CONFIG1_RESET   32'h3E5B_2D80   // 32 TLB entries, 4-way 16B lines

// Exception vectors
`define CP0_BOOT_VECTOR     32'hBFC0_0380
`define CP0_EXC_OFFSET      32'h0000_0180

`endif

// File: design/cp0Pkg.sv
package cp0Pkg;

    // Data word or full register value
    typedef logic [31:0] word;

    // Register number and select field of mtc0/mfc0
    typedef logic [4:0] regAddr;
    typedef logic [2:0] regSel;

    // Hardware interrupt lines IP7..IP2
    typedef logic [5:0] intVec;

    // Values of Cause.ExcCode
    typedef enum logic [4:0] {
        ExcInt  = 5'd0,
        ExcAdel = 5'd4,    // Address error on load or fetch
        ExcAdes = 5'd5,    // Address error on store
        ExcSys  = 5'd8,
        ExcBp   = 5'd9,
        ExcRi   = 5'd10,
        ExcOv   = 5'd12
    } excCode;

endpackage

// File: design/cp0Regs.sv
`timescale 1ns/10ps
`include "cp0_settings.svh"

module cp0Regs (
    input  logic           clk,
    input  logic           rst,
    input  logic           wrEn0,
    input  logic           wrEn1,
    input  cp0Pkg::regAddr wrAddr0,
    input  cp0Pkg::regAddr wrAddr1,
    input  cp0Pkg::regSel  wrSel0,
    input  cp0Pkg::regSel  wrSel1,
    input  cp0Pkg::word    wrData0,
    input  cp0Pkg::word    wrData1,
    input  cp0Pkg::regAddr rdAddr0,
    input  cp0Pkg::regAddr rdAddr1,
    input  cp0Pkg::regSel  rdSel0,
    input  cp0Pkg::regSel  rdSel1,
    input  cp0Pkg::intVec  hwInt,
    input  logic           excTake,
    input  logic           excRecordEpc,
    input  logic           excLoadBad,
    input  logic           eretTake,
    input  cp0Pkg::excCode excCodeSel,
    input  cp0Pkg::word    excPc,
    input  cp0Pkg::word    excBadAddr,
    input  logic           excInDelaySlot,
    output cp0Pkg::word    rdData0,
    output cp0Pkg::word    rdData1,
    output cp0Pkg::word    status,
    output cp0Pkg::word    cause,
    output cp0Pkg::word    epc,
    output cp0Pkg::word    eBase,
    output logic           timerInt
);

    cp0Pkg::word indexReg;
    cp0Pkg::word entryLo0;
    cp0Pkg::word entryLo1;
    cp0Pkg::word contextReg;
    cp0Pkg::word pageMask;
    cp0Pkg::word wired;
    cp0Pkg::word badVAddr;
    cp0Pkg::word count;
    cp0Pkg::word entryHi;
    cp0Pkg::word compare;
    cp0Pkg::word statusReg;
    cp0Pkg::word causeReg;
    cp0Pkg::word epcReg;
    cp0Pkg::word eBaseReg;
    cp0Pkg::word configReg;
    cp0Pkg::word errorEpc;
    logic        divTick;    // Count advances when set

    function automatic cp0Pkg::word merge(input cp0Pkg::word old, input cp0Pkg::word data,
                                          input cp0Pkg::word mask);
        return (old & ~mask) | (data & mask);
    endfunction

    // One mtc0 port; the later call wins on the same register
    task automatic applyWrite(input logic en, input cp0Pkg::regAddr addr,
                              input cp0Pkg::regSel sel, input cp0Pkg::word data);
        if (en && sel == 3'd1 && addr == `CP0_PRID) begin
            eBaseReg <= merge(eBaseReg, data, `CP0_EBASE_MASK);
        end else if (en && sel == 3'd0) begin
            case (addr)
                `CP0_INDEX:    indexReg   <= merge(indexReg, data, `CP0_INDEX_MASK);
                `CP0_ENTRYLO0: entryLo0   <= merge(entryLo0, data, `CP0_ENTRYLO0_MASK);
                `CP0_ENTRYLO1: entryLo1   <= merge(entryLo1, data, `CP0_ENTRYLO1_MASK);
                `CP0_CONTEXT:  contextReg <= merge(contextReg, data, `CP0_CONTEXT_MASK);
                `CP0_PAGEMASK: pageMask   <= merge(pageMask, data, `CP0_PAGEMASK_MASK);
                `CP0_WIRED:    wired      <= merge(wired, data, `CP0_WIRED_MASK);
                `CP0_COUNT:    count      <= merge(count, data, `CP0_COUNT_MASK);
                `CP0_ENTRYHI:  entryHi    <= merge(entryHi, data, `CP0_ENTRYHI_MASK);
                `CP0_COMPARE: begin
                    compare      <= merge(compare, data, `CP0_COMPARE_MASK);
                    causeReg[30] <= 1'b0;    // Acknowledge timer
                end
                `CP0_STATUS:   statusReg  <= merge(statusReg, data, `CP0_STATUS_MASK);
                `CP0_CAUSE: begin
                    causeReg[23:22] <= data[23:22];    // IV, WP
                    causeReg[9:8]   <= data[9:8];      // IP1..IP0
                end
                `CP0_EPC:      epcReg     <= merge(epcReg, data, `CP0_EPC_MASK);
                `CP0_CONFIG:   configReg  <= merge(configReg, data, `CP0_CONFIG_MASK);
                `CP0_ERROREPC: errorEpc   <= merge(errorEpc, data, `CP0_ERROREPC_MASK);
                default: ;
            endcase
        end
    endtask

    always_ff @(posedge clk) begin
        if (rst) begin
            statusReg <= `CP0_STATUS_RESET;
            causeReg  <= '0;
            count     <= '0;
            divTick   <= 1'b0;
            compare   <= '1;    // Far from Count after reset
            eBaseReg  <= `CP0_EBASE_RESET;
            configReg <= `CP0_CONFIG_RESET;
        end else begin
            divTick         <= ~divTick;
            count           <= count + {31'd0, divTick};
            causeReg[15:10] <= hwInt;
            if (count == compare) begin
                causeReg[30] <= 1'b1;
            end
            if (!excTake && !eretTake) begin
                applyWrite(wrEn1, wrAddr1, wrSel1, wrData1);
                applyWrite(wrEn0, wrAddr0, wrSel0, wrData0);
            end
            if (excTake) begin
                statusReg[1] <= 1'b1;
                if (excRecordEpc) begin
                    epcReg         <= excInDelaySlot ? excPc - 32'd4 : excPc;
                    causeReg[31]   <= excInDelaySlot;
                    causeReg[6:2]  <= excCodeSel;
                end
                if (excLoadBad) begin
                    badVAddr <= excBadAddr;
                end
            end
            if (eretTake) begin
                statusReg[1] <= 1'b0;
            end
        end
    end

    function automatic cp0Pkg::word readReg(input cp0Pkg::regAddr addr,
                                            input cp0Pkg::regSel sel);
        cp0Pkg::word value;
        value = '0;
        if (sel == 3'd0) begin
            case (addr)
                `CP0_INDEX:    value = indexReg;
                `CP0_ENTRYLO0: value = entryLo0;
                `CP0_ENTRYLO1: value = entryLo1;
                `CP0_CONTEXT:  value = contextReg;
                `CP0_PAGEMASK: value = pageMask;
                `CP0_WIRED:    value = wired;
                `CP0_BADVADDR: value = badVAddr;
                `CP0_COUNT:    value = count;
                `CP0_ENTRYHI:  value = entryHi;
                `CP0_COMPARE:  value = compare;
                `CP0_STATUS:   value = statusReg;
                `CP0_CAUSE:    value = causeReg;
                `CP0_EPC:      value = epcReg;
                `CP0_PRID:     value = `CP0_PRID_VALUE;
                `CP0_CONFIG:   value = configReg;
                `CP0_ERROREPC: value = errorEpc;
                default:       value = '0;
            endcase
        end else if (sel == 3'd1) begin
            if (addr == `CP0_PRID) begin
                value = eBaseReg;
            end else if (addr == `CP0_CONFIG) begin
                value = `CP0_CONFIG1_RESET;    // Config1 is read-only
            end
        end
        return value;
    endfunction

    always_comb begin
        rdData0 = readReg(rdAddr0, rdSel0);
        rdData1 = readReg(rdAddr1, rdSel1);
    end

    assign status   = statusReg;
    assign cause    = causeReg;
    assign epc      = epcReg;
    assign eBase    = eBaseReg;
    assign timerInt = causeReg[30];

endmodule

// File: design/exceptionUnit.sv
`timescale 1ns/10ps
`include "cp0_settings.svh"

module exceptionUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           commitValid,
    input  logic           commitInDelaySlot,
    input  cp0Pkg::word    commitPc,
    input  cp0Pkg::word    commitBadAddr,
    input  logic           reqAdel,
    input  logic           reqAdes,
    input  logic           reqRi,
    input  logic           reqSys,
    input  logic           reqBp,
    input  logic           reqOv,
    input  logic           reqEret,
    input  cp0Pkg::word    status,
    input  cp0Pkg::word    cause,
    input  cp0Pkg::word    epc,
    input  cp0Pkg::word    eBase,
    output logic           excTake,
    output logic           excRecordEpc,
    output logic           excLoadBad,
    output logic           eretTake,
    output cp0Pkg::excCode excCodeSel,
    output logic           flush,
    output cp0Pkg::word    redirectPc
);

    logic        intPending;
    cp0Pkg::word excVector;

    // IE set, EXL clear, some unmasked IP line
    assign intPending = status[0] && !status[1] && (|(cause[15:8] & status[15:8]));

    always_comb begin
        excTake    = commitValid;
        excLoadBad = 1'b0;
        excCodeSel = cp0Pkg::ExcInt;
        if (intPending) begin
            excCodeSel = cp0Pkg::ExcInt;
        end else if (reqAdel) begin
            excCodeSel = cp0Pkg::ExcAdel;
            excLoadBad = commitValid;
        end else if (reqAdes) begin
            excCodeSel = cp0Pkg::ExcAdes;
            excLoadBad = commitValid;
        end else if (reqRi) begin
            excCodeSel = cp0Pkg::ExcRi;
        end else if (reqSys) begin
            excCodeSel = cp0Pkg::ExcSys;
        end else if (reqBp) begin
            excCodeSel = cp0Pkg::ExcBp;
        end else if (reqOv) begin
            excCodeSel = cp0Pkg::ExcOv;
        end else begin
            excTake = 1'b0;
        end
    end

    assign excRecordEpc = excTake && !status[1];    // Nested ones keep EPC
    assign eretTake     = commitValid && reqEret && !excTake;

    assign excVector = status[22] ? `CP0_BOOT_VECTOR
                                  : {eBase[31:12], 12'h000} + `CP0_EXC_OFFSET;

    always_ff @(posedge clk) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= excTake || eretTake;
        end
    end

    always_ff @(posedge clk) begin
        if (excTake) begin
            redirectPc <= excVector;
        end else if (eretTake) begin
            redirectPc <= epc;
        end
    end

endmodule

// File: design/cp0Top.sv
`timescale 1ns/10ps

module cp0Top (
    input  logic           clk,
    input  logic           rst,
    input  logic           wrEn0,
    input  logic           wrEn1,
    input  cp0Pkg::regAddr wrAddr0,
    input  cp0Pkg::regAddr wrAddr1,
    input  cp0Pkg::regSel  wrSel0,
    input  cp0Pkg::regSel  wrSel1,
    input  cp0Pkg::word    wrData0,
    input  cp0Pkg::word    wrData1,
    input  cp0Pkg::regAddr rdAddr0,
    input  cp0Pkg::regAddr rdAddr1,
    input  cp0Pkg::regSel  rdSel0,
    input  cp0Pkg::regSel  rdSel1,
    output cp0Pkg::word    rdData0,
    output cp0Pkg::word    rdData1,
    input  cp0Pkg::intVec  hwInt,
    input  logic           commitValid,
    input  logic           commitInDelaySlot,
    input  cp0Pkg::word    commitPc,
    input  cp0Pkg::word    commitBadAddr,
    input  logic           reqAdel,
    input  logic           reqAdes,
    input  logic           reqRi,
    input  logic           reqSys,
    input  logic           reqBp,
    input  logic           reqOv,
    input  logic           reqEret,
    output logic           flush,
    output cp0Pkg::word    redirectPc,
    output logic           timerInt,
    output cp0Pkg::word    statusOut
);

    logic           excTake;
    logic           excRecordEpc;
    logic           excLoadBad;
    logic           eretTake;
    cp0Pkg::excCode excCodeSel;
    cp0Pkg::word    cause;
    cp0Pkg::word    epc;
    cp0Pkg::word    eBase;

    cp0Regs regs (
        .clk(clk), .rst(rst),
        .wrEn0(wrEn0), .wrEn1(wrEn1), .wrAddr0(wrAddr0), .wrAddr1(wrAddr1),
        .wrSel0(wrSel0), .wrSel1(wrSel1), .wrData0(wrData0), .wrData1(wrData1),
        .rdAddr0(rdAddr0), .rdAddr1(rdAddr1), .rdSel0(rdSel0), .rdSel1(rdSel1),
        .hwInt(hwInt),
        .excTake(excTake), .excRecordEpc(excRecordEpc), .excLoadBad(excLoadBad),
        .eretTake(eretTake), .excCodeSel(excCodeSel),
        .excPc(commitPc), .excBadAddr(commitBadAddr), .excInDelaySlot(commitInDelaySlot),
        .rdData0(rdData0), .rdData1(rdData1),
        .status(statusOut), .cause(cause), .epc(epc), .eBase(eBase),
        .timerInt(timerInt)
    );

    exceptionUnit excUnit (
        .clk(clk), .rst(rst),
        .commitValid(commitValid), .commitInDelaySlot(commitInDelaySlot),
        .commitPc(commitPc), .commitBadAddr(commitBadAddr),
        .reqAdel(reqAdel), .reqAdes(reqAdes), .reqRi(reqRi), .reqSys(reqSys),
        .reqBp(reqBp), .reqOv(reqOv), .reqEret(reqEret),
        .status(statusOut), .cause(cause), .epc(epc), .eBase(eBase),
        .excTake(excTake), .excRecordEpc(excRecordEpc), .excLoadBad(excLoadBad),
        .eretTake(eretTake), .excCodeSel(excCodeSel),
        .flush(flush), .redirectPc(redirectPc)
    );

endmodule

// File: dv/cp0Tb.sv
`timescale 1ns/10ps
`include "cp0_settings.svh"

module cp0Tb;

    typedef enum logic [2:0] {
        OpCheck, OpRead, OpWrite, OpWrRand, OpWrBoth, OpCommit, OpIrq, OpTimer
    } opKind;

    typedef struct packed {
        opKind          kind;
        logic           pipe;
        cp0Pkg::regAddr addr;
        cp0Pkg::regSel  sel;
        logic [6:0]     flags;    // eret, ov, bp, sys, ri, ades, adel
        logic           slot;
        cp0Pkg::word    data;
        cp0Pkg::word    expected;
    } stepRec;

    localparam logic [6:0] flagAdel = 7'h01;
    localparam logic [6:0] flagAdes = 7'h02;
    localparam logic [6:0] flagRi   = 7'h04;
    localparam logic [6:0] flagSys  = 7'h08;
    localparam logic [6:0] flagBp   = 7'h10;
    localparam logic [6:0] flagOv   = 7'h20;
    localparam logic [6:0] flagEret = 7'h40;

    logic clk, rst;
    logic wrEn0, wrEn1;
    cp0Pkg::regAddr wrAddr0, wrAddr1, rdAddr0, rdAddr1;
    cp0Pkg::regSel wrSel0, wrSel1, rdSel0, rdSel1;
    cp0Pkg::word wrData0, wrData1, rdData0, rdData1;
    cp0Pkg::intVec hwInt;
    logic commitValid, commitInDelaySlot;
    cp0Pkg::word commitPc, commitBadAddr;
    logic reqAdel, reqAdes, reqRi, reqSys, reqBp, reqOv, reqEret;
    logic flush, timerInt;
    cp0Pkg::word redirectPc, statusOut;

    stepRec steps[$];
    cp0Pkg::word m [0:31];    // Reference copy of the select 0 registers
    cp0Pkg::word mEBase;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;

    cp0Top dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic checkWord(input string name, input cp0Pkg::word actual,
                             input cp0Pkg::word expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic addStep(input opKind kind, input logic pipe, input cp0Pkg::regAddr addr,
                           input cp0Pkg::regSel sel, input logic [6:0] flags,
                           input logic slot, input cp0Pkg::word data,
                           input cp0Pkg::word expected);
        steps.push_back('{kind, pipe, addr, sel, flags, slot, data, expected});
    endtask

    function automatic cp0Pkg::word maskOf(input cp0Pkg::regAddr addr, input cp0Pkg::regSel sel);
        if (sel == 3'd1) begin
            return (addr == `CP0_PRID) ? `CP0_EBASE_MASK : 32'd0;
        end
        case (addr)
            `CP0_STATUS: return `CP0_STATUS_MASK;
            `CP0_CAUSE:  return `CP0_CAUSE_MASK;
            `CP0_EPC:    return `CP0_EPC_MASK;
            `CP0_CONFIG: return `CP0_CONFIG_MASK;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic modelWrite(input cp0Pkg::regAddr addr, input cp0Pkg::regSel sel,
                              input cp0Pkg::word data);
        cp0Pkg::word mask;
        mask = maskOf(addr, sel);
        if (sel == 3'd1 && addr == `CP0_PRID) begin
            mEBase = (mEBase & ~mask) | (data & mask);
        end else if (sel == 3'd0) begin
            m[addr] = (m[addr] & ~mask) | (data & mask);
        end
    endtask

    function automatic cp0Pkg::word modelRead(input cp0Pkg::regAddr addr,
                                              input cp0Pkg::regSel sel);
        if (sel == 3'd0) begin
            return m[addr];
        end else if (sel == 3'd1 && addr == `CP0_PRID) begin
            return mEBase;
        end else if (sel == 3'd1 && addr == `CP0_CONFIG) begin
            return `CP0_CONFIG1_RESET;
        end
        return 32'd0;
    endfunction

    // Priority pick that records EPC/BD/ExcCode only when EXL was clear
    task automatic modelCommit(input logic [6:0] flags, input cp0Pkg::word pc,
                               input cp0Pkg::word bad, input logic slot,
                               output cp0Pkg::word target);
        logic intOn;
        logic taken;
        logic loadBad;
        cp0Pkg::excCode code;
        intOn = m[`CP0_STATUS][0] && !m[`CP0_STATUS][1]
                && ((m[`CP0_CAUSE][15:8] & m[`CP0_STATUS][15:8]) != 8'd0);
        taken = 1'b1;
        loadBad = 1'b0;
        code = cp0Pkg::ExcInt;
        if (intOn) begin
            code = cp0Pkg::ExcInt;
        end else if (flags[0]) begin
            code = cp0Pkg::ExcAdel;
            loadBad = 1'b1;
        end else if (flags[1]) begin
            code = cp0Pkg::ExcAdes;
            loadBad = 1'b1;
        end else if (flags[2]) begin
            code = cp0Pkg::ExcRi;
        end else if (flags[3]) begin
            code = cp0Pkg::ExcSys;
        end else if (flags[4]) begin
            code = cp0Pkg::ExcBp;
        end else if (flags[5]) begin
            code = cp0Pkg::ExcOv;
        end else begin
            taken = 1'b0;
        end
        target = m[`CP0_EPC];
        if (taken) begin
            target = m[`CP0_STATUS][22] ? `CP0_BOOT_VECTOR
                                        : {mEBase[31:12], 12'h000} + `CP0_EXC_OFFSET;
            if (!m[`CP0_STATUS][1]) begin
                m[`CP0_EPC] = slot ? pc - 32'd4 : pc;
                m[`CP0_CAUSE][31] = slot;
                m[`CP0_CAUSE][6:2] = code;
            end
            if (loadBad) m[`CP0_BADVADDR] = bad;
            m[`CP0_STATUS][1] = 1'b1;
        end else if (flags[6]) begin
            m[`CP0_STATUS][1] = 1'b0;
        end
    endtask

    task automatic idleInputs();
        wrEn0 <= 1'b0;
        wrEn1 <= 1'b0;
        commitValid <= 1'b0;
        commitInDelaySlot <= 1'b0;
        {reqEret, reqOv, reqBp, reqSys, reqRi, reqAdes, reqAdel} <= 7'd0;
    endtask

    task automatic driveWrite(input logic pipe, input cp0Pkg::regAddr addr,
                              input cp0Pkg::regSel sel, input cp0Pkg::word data);
        if (pipe) begin
            wrEn1 <= 1'b1;
            wrAddr1 <= addr;
            wrSel1 <= sel;
            wrData1 <= data;
        end else begin
            wrEn0 <= 1'b1;
            wrAddr0 <= addr;
            wrSel0 <= sel;
            wrData0 <= data;
        end
    endtask

    // Call right after a rising edge
    task automatic readBack(input logic pipe, input cp0Pkg::regAddr addr,
                            input cp0Pkg::regSel sel, output cp0Pkg::word value);
        if (pipe) begin
            rdAddr1 <= addr;
            rdSel1 <= sel;
        end else begin
            rdAddr0 <= addr;
            rdSel0 <= sel;
        end
        @(negedge clk);
        value = pipe ? rdData1 : rdData0;
    endtask

    task automatic runTimer(input cp0Pkg::word advance);
        cp0Pkg::word first;
        cp0Pkg::word second;
        cp0Pkg::word target;
        int waited;
        readBack(1'b0, `CP0_COUNT, 3'd0, first);
        repeat (4) @(posedge clk);
        @(negedge clk);
        second = rdData0;
        checkWord("Count advance over 4 cycles", second - first, advance);
        target = second + 32'd3;
        @(posedge clk);
        driveWrite(1'b0, `CP0_COMPARE, 3'd0, target);
        @(posedge clk);
        idleInputs();
        waited = 0;
        @(negedge clk);
        while (!timerInt && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (timerInt) else begin
            errors++;
            $display("timerInt did not rise after Count reached Compare %h", target);
        end
        if (timerInt) begin
            // TI rises one cycle after the match, before Count leaves target
            checkWord("Count at timerInt", rdData0, target);
        end
        @(posedge clk);
        driveWrite(1'b0, `CP0_COMPARE, 3'd0, target + 32'd100);
        @(posedge clk);
        idleInputs();
        @(negedge clk);
        checkWord("timerInt after Compare write", {31'd0, timerInt}, 32'd0);
    endtask

    task automatic runStep(input stepRec st);
        cp0Pkg::word value;
        cp0Pkg::word d0;
        cp0Pkg::word d1;
        cp0Pkg::word target;
        case (st.kind)
            OpCheck: begin
                readBack(st.pipe, st.addr, st.sel, value);
                checkWord($sformatf("reg %0d sel %0d", st.addr, st.sel), value, st.expected);
            end
            OpRead: begin
                readBack(st.pipe, st.addr, st.sel, value);
                checkWord($sformatf("reg %0d sel %0d", st.addr, st.sel), value,
                          modelRead(st.addr, st.sel));
            end
            OpWrite, OpWrRand: begin
                d0 = (st.kind == OpWrRand) ? $urandom() : st.data;
                driveWrite(st.pipe, st.addr, st.sel, d0);
                modelWrite(st.addr, st.sel, d0);
            end
            OpWrBoth: begin
                d0 = $urandom();
                d1 = $urandom();
                driveWrite(1'b0, st.addr, st.sel, d0);
                driveWrite(1'b1, st.addr, st.sel, d1);
                modelWrite(st.addr, st.sel, d1);
                modelWrite(st.addr, st.sel, d0);    // Port 0 has priority
            end
            OpCommit: begin
                commitValid <= 1'b1;
                commitPc <= st.data;
                commitBadAddr <= st.data ^ 32'h0000_0FF3;
                commitInDelaySlot <= st.slot;
                {reqEret, reqOv, reqBp, reqSys, reqRi, reqAdes, reqAdel} <= st.flags;
                modelCommit(st.flags, st.data, st.data ^ 32'h0000_0FF3, st.slot, target);
                @(posedge clk);
                idleInputs();
                @(negedge clk);
                checkWord("flush", {31'd0, flush}, st.expected);
                if (st.expected[0]) checkWord("redirectPc", redirectPc, target);
                checkWord("statusOut", statusOut, m[`CP0_STATUS]);
            end
            OpIrq: begin
                hwInt <= st.data[5:0];
                m[`CP0_CAUSE][15:10] = st.data[5:0];
            end
            default: runTimer(st.expected);
        endcase
    endtask

    task automatic loadSteps();
        addStep(OpCheck, 1'b0, `CP0_STATUS, 3'd0, '0, 1'b0, '0, `CP0_STATUS_RESET);
        addStep(OpCheck, 1'b1, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, 32'd0);
        addStep(OpCheck, 1'b0, `CP0_PRID, 3'd0, '0, 1'b0, '0, `CP0_PRID_VALUE);
        addStep(OpCheck, 1'b1, `CP0_PRID, 3'd1, '0, 1'b0, '0, `CP0_EBASE_RESET);
        addStep(OpCheck, 1'b0, `CP0_CONFIG, 3'd0, '0, 1'b0, '0, `CP0_CONFIG_RESET);
        addStep(OpCheck, 1'b1, `CP0_CONFIG, 3'd1, '0, 1'b0, '0, `CP0_CONFIG1_RESET);
        addStep(OpCheck, 1'b0, 5'd7, 3'd0, '0, 1'b0, '0, 32'd0);
        addStep(OpCheck, 1'b1, 5'd20, 3'd0, '0, 1'b0, '0, 32'd0);
        addStep(OpCheck, 1'b0, `CP0_STATUS, 3'd2, '0, 1'b0, '0, 32'd0);
        addStep(OpWrRand, 1'b0, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpWrRand, 1'b1, `CP0_PRID, 3'd1, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b0, `CP0_PRID, 3'd1, '0, 1'b0, '0, '0);
        addStep(OpWrRand, 1'b0, `CP0_CONFIG, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_CONFIG, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpWrRand, 1'b1, `CP0_STATUS, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b0, `CP0_STATUS, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpWrite, 1'b0, `CP0_STATUS, 3'd0, '0, 1'b0, 32'h0040_0000, '0);
        addStep(OpWrBoth, 1'b0, `CP0_EPC, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_EPC, 3'd0, '0, 1'b0, '0, '0);
        // Exceptions through the boot vector, then nesting and eret
        addStep(OpCommit, 1'b0, '0, '0, flagAdel, 1'b0, 32'h8000_1000, 32'd1);
        addStep(OpRead, 1'b0, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_EPC, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b0, `CP0_BADVADDR, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_STATUS, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagSys, 1'b0, 32'h8000_2000, 32'd1);
        addStep(OpRead, 1'b0, `CP0_EPC, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagEret, 1'b0, 32'h8000_2004, 32'd1);
        addStep(OpRead, 1'b0, `CP0_STATUS, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagAdes, 1'b1, 32'h8000_3004, 32'd1);
        addStep(OpRead, 1'b0, `CP0_EPC, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b0, `CP0_BADVADDR, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagEret, 1'b0, 32'h8000_3008, 32'd1);
        addStep(OpCommit, 1'b0, '0, '0, flagRi | flagOv, 1'b0, 32'h8000_4000, 32'd1);
        addStep(OpRead, 1'b0, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagEret, 1'b0, 32'h8000_4004, 32'd1);
        addStep(OpWrite, 1'b1, `CP0_STATUS, 3'd0, '0, 1'b0, 32'h0000_0000, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagOv, 1'b0, 32'h8000_4800, 32'd1);
        addStep(OpRead, 1'b1, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagEret, 1'b0, 32'h8000_4804, 32'd1);
        addStep(OpCommit, 1'b0, '0, '0, flagBp, 1'b0, 32'h8000_4900, 32'd1);
        addStep(OpRead, 1'b0, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagEret, 1'b0, 32'h8000_4904, 32'd1);
        // Interrupt on IP2, taken over Sys and Bp, then masked off
        addStep(OpIrq, 1'b0, '0, '0, '0, 1'b0, 32'h0000_0001, '0);
        addStep(OpRead, 1'b1, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpWrite, 1'b0, `CP0_STATUS, 3'd0, '0, 1'b0, 32'h0000_0401, '0);
        addStep(OpCommit, 1'b0, '0, '0, flagSys | flagBp, 1'b0, 32'h8000_5000, 32'd1);
        addStep(OpRead, 1'b0, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpRead, 1'b1, `CP0_EPC, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpIrq, 1'b0, '0, '0, '0, 1'b0, 32'h0000_0000, '0);
        addStep(OpWrite, 1'b1, `CP0_STATUS, 3'd0, '0, 1'b0, 32'h0000_0801, '0);
        addStep(OpIrq, 1'b0, '0, '0, '0, 1'b0, 32'h0000_0001, '0);
        addStep(OpRead, 1'b0, `CP0_CAUSE, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpCommit, 1'b0, '0, '0, '0, 1'b0, 32'h8000_6000, 32'd0);
        addStep(OpRead, 1'b1, `CP0_STATUS, 3'd0, '0, 1'b0, '0, '0);
        addStep(OpTimer, 1'b0, '0, '0, '0, 1'b0, '0, 32'd2);
    endtask

    initial begin
        void'($urandom(32'hea93));
        clk = 1'b0;
        rst = 1'b1;
        wrEn0 = 1'b0;
        wrEn1 = 1'b0;
        wrAddr0 = '0;
        wrAddr1 = '0;
        wrSel0 = '0;
        wrSel1 = '0;
        wrData0 = '0;
        wrData1 = '0;
        rdAddr0 = '0;
        rdAddr1 = '0;
        rdSel0 = '0;
        rdSel1 = '0;
        hwInt = '0;
        commitValid = 1'b0;
        commitInDelaySlot = 1'b0;
        commitPc = '0;
        commitBadAddr = '0;
        {reqEret, reqOv, reqBp, reqSys, reqRi, reqAdes, reqAdel} = 7'd0;
        foreach (m[i]) m[i] = 32'd0;
        m[`CP0_STATUS] = `CP0_STATUS_RESET;
        m[`CP0_PRID] = `CP0_PRID_VALUE;
        m[`CP0_CONFIG] = `CP0_CONFIG_RESET;
        mEBase = `CP0_EBASE_RESET;
        loadSteps();
        limit = steps.size() * 8 + 100;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            idleInputs();
            runStep(steps[i]);
        end
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+design
design/cp0Pkg.sv
design/cp0Regs.sv
design/exceptionUnit.sv
design/cp0Top.sv
dv/cp0Tb.sv

// File: run.sh
#!/bin/sh
# Builds the CP0 testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cp0Tb -f flist.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vcp0Tb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
